//--- hdl/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Data memory geometry

// Word width in bits
`define MEM_DATA_WIDTH 32

// One enable per byte lane
`define MEM_BE_WIDTH 4

// Words in the data RAM
`define MEM_DEPTH 1024

// Word address, log2 of the depth
`define MEM_ADDR_WIDTH 10

`endif

//--- hdl/mem_types_pkg.sv
`include "mem_consts.svh"

package mem_types_pkg;

  // Memory operation seen by both requesters
  typedef enum logic {
    MEM_READ  = 1'b0, // Load, returns data with rvalid
    MEM_WRITE = 1'b1  // Store, rvalid only acknowledges
  } mem_op_e;

  // Single data word
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;

  // Word address, not byte address
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // Bit n enables byte lane n
  typedef logic [`MEM_BE_WIDTH-1:0] mem_be_t;

endpackage

//--- hdl/arb_pkg.sv
package arb_pkg;

  // Port that wins the next contention
  typedef enum logic {
    PRIO_PORT0 = 1'b0,
    PRIO_PORT1 = 1'b1
  } arb_state_e;

  // Owner of the access in flight
  typedef enum logic {
    PORT0 = 1'b0, // Loader / debug master
    PORT1 = 1'b1  // Core load/store unit
  } port_id_e;

endpackage

//--- hdl/sp_ram.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module sp_ram (
  input  logic                   clk,
  input  logic                   en_i,    // Access this cycle
  input  logic                   we_i,    // Write when set, else read
  input  mem_types_pkg::mem_addr_t addr_i,
  input  mem_types_pkg::mem_be_t   be_i,
  input  mem_types_pkg::mem_data_t wdata_i,
  output mem_types_pkg::mem_data_t rdata_o  // Valid one cycle after a read
);

  import mem_types_pkg::*;

  // Bits per byte lane
  localparam int LANE_WIDTH = `MEM_DATA_WIDTH / `MEM_BE_WIDTH;

  // Storage array, contents undefined until written
  mem_data_t mem_q [`MEM_DEPTH];

  // Byte-lane writes
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int lane = 0; lane < `MEM_BE_WIDTH; lane++) begin
        if (be_i[lane]) begin
          mem_q[addr_i][lane*LANE_WIDTH +: LANE_WIDTH] <=
            wdata_i[lane*LANE_WIDTH +: LANE_WIDTH];
        end
      end
    end
  end

  // Registered read port
  // Sees old contents, the write lands at the same edge
  always_ff @(posedge clk) begin
    if (en_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

//--- hdl/ram_mux.sv
`timescale 1ns/1ns

module ram_mux (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // Port 0, loader or debug master
  input  logic                     port0_req_i,
  input  mem_types_pkg::mem_op_e   port0_op_i,
  input  mem_types_pkg::mem_addr_t port0_addr_i,
  input  mem_types_pkg::mem_be_t   port0_be_i,
  input  mem_types_pkg::mem_data_t port0_wdata_i,
  output logic                     port0_gnt_o,
  output logic                     port0_rvalid_o,
  output mem_types_pkg::mem_data_t port0_rdata_o,

  // Port 1, core load/store unit
  input  logic                     port1_req_i,
  input  mem_types_pkg::mem_op_e   port1_op_i,
  input  mem_types_pkg::mem_addr_t port1_addr_i,
  input  mem_types_pkg::mem_be_t   port1_be_i,
  input  mem_types_pkg::mem_data_t port1_wdata_i,
  output logic                     port1_gnt_o,
  output logic                     port1_rvalid_o,
  output mem_types_pkg::mem_data_t port1_rdata_o,

  // Single-port RAM side
  output logic                     ram_en_o,
  output logic                     ram_we_o,
  output mem_types_pkg::mem_addr_t ram_addr_o,
  output mem_types_pkg::mem_be_t   ram_be_o,
  output mem_types_pkg::mem_data_t ram_wdata_o,
  input  mem_types_pkg::mem_data_t ram_rdata_i
);

  import mem_types_pkg::*;
  import arb_pkg::*;

  arb_state_e arb_state_q;  // Round-robin priority
  port_id_e   sel_port;     // Winner this cycle
  logic       both_req;     // Contention
  logic       accept;       // Some port granted

  mem_op_e    sel_op;

  logic       rvalid_q;     // Response due this cycle
  port_id_e   owner_q;      // Port the response goes to

  // Arbitration
  assign both_req = port0_req_i && port1_req_i;

  always_comb begin
    if (both_req) begin
      // Priority state breaks the tie
      sel_port = (arb_state_q == PRIO_PORT0) ? PORT0 : PORT1;
    end else if (port1_req_i) begin
      sel_port = PORT1;
    end else begin
      sel_port = PORT0;  // Port 0 alone, or nobody
    end
  end

  assign accept      = port0_req_i || port1_req_i;
  assign port0_gnt_o = port0_req_i && (sel_port == PORT0);
  assign port1_gnt_o = port1_req_i && (sel_port == PORT1);

  // Priority flips only when someone actually lost
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      arb_state_q <= PRIO_PORT0;
    end else if (both_req) begin
      arb_state_q <= (arb_state_q == PRIO_PORT0) ? PRIO_PORT1 : PRIO_PORT0;
    end
  end

  // Request steering onto the RAM
  always_comb begin
    if (sel_port == PORT1) begin
      sel_op      = port1_op_i;
      ram_addr_o  = port1_addr_i;
      ram_be_o    = port1_be_i;
      ram_wdata_o = port1_wdata_i;
    end else begin
      sel_op      = port0_op_i;
      ram_addr_o  = port0_addr_i;
      ram_be_o    = port0_be_i;
      ram_wdata_o = port0_wdata_i;
    end
  end

  assign ram_en_o = accept;
  assign ram_we_o = accept && (sel_op == MEM_WRITE);

  // Response tracking
  // One accepted access may overlap the previous response
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      owner_q  <= PORT0;
    end else begin
      rvalid_q <= accept;  // Reads and writes both answer
      if (accept) begin
        owner_q <= sel_port;
      end
    end
  end

  // Response return, the idle port sees zero data
  assign port0_rvalid_o = rvalid_q && (owner_q == PORT0);
  assign port1_rvalid_o = rvalid_q && (owner_q == PORT1);

  assign port0_rdata_o = port0_rvalid_o ? ram_rdata_i : '0;
  assign port1_rdata_o = port1_rvalid_o ? ram_rdata_i : '0;  // Stale on writes, ignored

endmodule

//--- hdl/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys (
  input  logic                     clk,
  input  logic                     arst_n_i,

  input  logic                     port0_req_i,
  input  mem_types_pkg::mem_op_e   port0_op_i,
  input  mem_types_pkg::mem_addr_t port0_addr_i,
  input  mem_types_pkg::mem_be_t   port0_be_i,
  input  mem_types_pkg::mem_data_t port0_wdata_i,
  output logic                     port0_gnt_o,
  output logic                     port0_rvalid_o,
  output mem_types_pkg::mem_data_t port0_rdata_o,

  input  logic                     port1_req_i,
  input  mem_types_pkg::mem_op_e   port1_op_i,
  input  mem_types_pkg::mem_addr_t port1_addr_i,
  input  mem_types_pkg::mem_be_t   port1_be_i,
  input  mem_types_pkg::mem_data_t port1_wdata_i,
  output logic                     port1_gnt_o,
  output logic                     port1_rvalid_o,
  output mem_types_pkg::mem_data_t port1_rdata_o
);

  import mem_types_pkg::*;

  // Mux to RAM
  logic      data_mem_en;
  logic      data_mem_we;
  mem_addr_t data_mem_addr;
  mem_be_t   data_mem_be;
  mem_data_t data_mem_wdata;
  mem_data_t data_mem_rdata;  // RAM back to mux

  ram_mux data_ram_mux (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .port0_req_i    (port0_req_i),
    .port0_op_i     (port0_op_i),
    .port0_addr_i   (port0_addr_i),
    .port0_be_i     (port0_be_i),
    .port0_wdata_i  (port0_wdata_i),
    .port0_gnt_o    (port0_gnt_o),
    .port0_rvalid_o (port0_rvalid_o),
    .port0_rdata_o  (port0_rdata_o),
    .port1_req_i    (port1_req_i),
    .port1_op_i     (port1_op_i),
    .port1_addr_i   (port1_addr_i),
    .port1_be_i     (port1_be_i),
    .port1_wdata_i  (port1_wdata_i),
    .port1_gnt_o    (port1_gnt_o),
    .port1_rvalid_o (port1_rvalid_o),
    .port1_rdata_o  (port1_rdata_o),
    .ram_en_o       (data_mem_en),
    .ram_we_o       (data_mem_we),
    .ram_addr_o     (data_mem_addr),
    .ram_be_o       (data_mem_be),
    .ram_wdata_o    (data_mem_wdata),
    .ram_rdata_i    (data_mem_rdata)
  );

  // Data RAM, one-cycle read latency
  sp_ram data_mem (
    .clk     (clk),
    .en_i    (data_mem_en),
    .we_i    (data_mem_we),
    .addr_i  (data_mem_addr),
    .be_i    (data_mem_be),
    .wdata_i (data_mem_wdata),
    .rdata_o (data_mem_rdata)
  );

endmodule

//--- tests/mem_subsys_properties.sv
`timescale 1ns/1ns

module mem_subsys_properties (
  input logic clk,
  input logic arst_n_i,
  input logic port0_req_i,
  input logic port1_req_i,
  input logic port0_gnt_o,
  input logic port1_gnt_o,
  input logic port0_rvalid_o,
  input logic port1_rvalid_o
);

  // Single RAM port, one winner per cycle
  a_one_grant: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(port0_gnt_o && port1_gnt_o))
    else $error("Both ports granted in the same cycle");

  a_gnt0_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    port0_gnt_o |-> port0_req_i)
    else $error("Port 0 granted without a request");

  a_gnt1_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    port1_gnt_o |-> port1_req_i)
    else $error("Port 1 granted without a request");

  // Fixed one-cycle response, reads and writes alike
  a_gnt0_rvalid: assert property (@(posedge clk) disable iff (!arst_n_i)
    port0_gnt_o |=> port0_rvalid_o)
    else $error("Port 0 grant not followed by rvalid");

  a_gnt1_rvalid: assert property (@(posedge clk) disable iff (!arst_n_i)
    port1_gnt_o |=> port1_rvalid_o)
    else $error("Port 1 grant not followed by rvalid");

  // No response out of thin air
  a_rvalid0_after_gnt: assert property (@(posedge clk) disable iff (!arst_n_i)
    port0_rvalid_o |-> $past(port0_gnt_o))
    else $error("Port 0 rvalid without a grant one cycle earlier");

  a_rvalid1_after_gnt: assert property (@(posedge clk) disable iff (!arst_n_i)
    port1_rvalid_o |-> $past(port1_gnt_o))
    else $error("Port 1 rvalid without a grant one cycle earlier");

endmodule

//--- tests/mem_subsys_tb.sv
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsys_tb;

  import mem_types_pkg::*;
  import arb_pkg::*;

  localparam int RAND_SEED      = 65348;
  localparam int RESET_CYCLES   = 3;
  localparam int IDLE_CYCLES    = 8;
  localparam int N_CONTENTION   = 8;   // Rounds, both ports each round
  localparam int N_CROSS        = 4;   // Write then read pairs
  localparam int N_RANDOM       = 60;  // Per port
  localparam int ADDR_SPAN      = 32;  // Small window, lots of address reuse
  localparam int TOTAL_OPS      = 2 * N_CONTENTION + 3 + 2 * N_CROSS + 2 * N_RANDOM;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 3 + RESET_CYCLES + 100;
  localparam int LANE           = `MEM_DATA_WIDTH / `MEM_BE_WIDTH;

  // Expected response, due at a monitor cycle
  typedef struct packed {
    logic        is_read;
    mem_data_t   data;
    logic [31:0] due;
  } resp_t;

  logic       clk;
  logic       arst_n_i;
  logic [1:0] req;                     // Index is the port
  mem_op_e    op [2];
  mem_addr_t  addr [2];
  mem_be_t    be [2];
  mem_data_t  wdata [2];
  logic [1:0] gnt;
  logic [1:0] rvalid;
  mem_data_t  rdata [2];

  mem_data_t   model_mem [`MEM_DEPTH];
  bit          known [`MEM_DEPTH];     // Word fully written at least once
  arb_state_e  exp_state;
  resp_t       resp_q [2][$];
  int unsigned mon_cycle;
  int unsigned cycle_cnt;
  int          pass_cnt, fail_cnt, fail_at_start;
  int          tests_passed, tests_failed;

  mem_subsys uut (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .port0_req_i    (req[0]),
    .port0_op_i     (op[0]),
    .port0_addr_i   (addr[0]),
    .port0_be_i     (be[0]),
    .port0_wdata_i  (wdata[0]),
    .port0_gnt_o    (gnt[0]),
    .port0_rvalid_o (rvalid[0]),
    .port0_rdata_o  (rdata[0]),
    .port1_req_i    (req[1]),
    .port1_op_i     (op[1]),
    .port1_addr_i   (addr[1]),
    .port1_be_i     (be[1]),
    .port1_wdata_i  (wdata[1]),
    .port1_gnt_o    (gnt[1]),
    .port1_rvalid_o (rvalid[1]),
    .port1_rdata_o  (rdata[1])
  );

  bind ram_mux mem_subsys_properties props (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .port0_req_i    (port0_req_i),
    .port1_req_i    (port1_req_i),
    .port0_gnt_o    (port0_gnt_o),
    .port1_gnt_o    (port1_gnt_o),
    .port0_rvalid_o (port0_rvalid_o),
    .port1_rvalid_o (port1_rvalid_o)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timed out after %0d cycles with requests still outstanding", cycle_cnt);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic check_rdata(input mem_data_t exp, input mem_data_t got);
    if (got === exp) pass_cnt++;
    else begin
      fail_cnt++;
      $display("ERROR @%0t: rdata expected %h, got %h", $time, exp, got);
    end
  endtask

  // exp_any low means no port may be granted
  task automatic check_grant(input port_id_e exp_port, input bit exp_any);
    port_id_e got;
    bit       ok;
    got = gnt[1] ? PORT1 : PORT0;
    if (exp_any) ok = ($countones(gnt) == 1) && (got == exp_port);
    else ok = (gnt == 2'b00);
    if (ok) pass_cnt++;
    else begin
      fail_cnt++;
      if (exp_any) $display("ERROR @%0t: expected grant to %s, got gnt=%b",
                            $time, exp_port.name(), gnt);
      else $display("ERROR @%0t: expected no grant, got gnt=%b", $time, gnt);
    end
  endtask

  task automatic check_rvalid(input port_id_e p, input bit exp);
    if (rvalid[p] === exp) pass_cnt++;
    else begin
      fail_cnt++;
      $display("ERROR @%0t: %s rvalid expected %b, got %b", $time, p.name(), exp, rvalid[p]);
    end
  endtask

  task automatic check_response(input port_id_e p);
    resp_t r;
    bit    due;
    due = (resp_q[p].size() > 0) && (resp_q[p][0].due == mon_cycle);
    check_rvalid(p, due);
    if (due) begin
      r = resp_q[p].pop_front();
      if (r.is_read) check_rdata(r.data, rdata[p]);  // Write data is don't care
    end
  endtask

  // Model side of an acceptance: queue the answer, then merge the write
  task automatic accept_model(input port_id_e p);
    resp_t r;
    r.is_read = (op[p] == MEM_READ);
    r.data    = model_mem[addr[p]];
    r.due     = mon_cycle + 1;
    resp_q[p].push_back(r);
    if (op[p] == MEM_WRITE) begin
      for (int b = 0; b < `MEM_BE_WIDTH; b++) begin
        if (be[p][b]) model_mem[addr[p]][b*LANE +: LANE] = wdata[p][b*LANE +: LANE];
      end
      if (be[p] == '1) known[addr[p]] = 1'b1;
    end
  endtask

  // Mid-cycle sampling, inputs and gnt settled
  always @(negedge clk) begin
    port_id_e win;
    if (arst_n_i) begin
      mon_cycle++;
      check_response(PORT0);
      check_response(PORT1);
      if (req == 2'b11) begin
        win       = (exp_state == PRIO_PORT0) ? PORT0 : PORT1;
        exp_state = (exp_state == PRIO_PORT0) ? PRIO_PORT1 : PRIO_PORT0;
      end else begin
        win = req[1] ? PORT1 : PORT0;
      end
      check_grant(win, req != 2'b00);
      if (req != 2'b00) accept_model(win);
    end
  end

  // Called 2 ns after a rising edge, returns at the same point
  task automatic issue(input port_id_e p, input mem_op_e o, input mem_addr_t a,
                       input mem_be_t b, input mem_data_t d);
    req[p]   = 1'b1;
    op[p]    = o;
    addr[p]  = a;
    be[p]    = b;
    wdata[p] = d;
    @(negedge clk);
    while (!gnt[p]) @(negedge clk);  // Held unchanged while losing
    @(posedge clk);
    #2;
    req[p] = 1'b0;
  endtask

  task automatic random_port(input port_id_e p, input int n_ops);
    mem_op_e   r_op;
    mem_addr_t r_addr;
    mem_be_t   r_be;
    repeat (n_ops) begin
      repeat ($urandom_range(2)) begin  // Idle gap, zero means back to back
        @(posedge clk);
        #2;
      end
      r_addr = mem_addr_t'($urandom_range(ADDR_SPAN - 1));
      r_op   = ($urandom_range(1) == 1) ? MEM_WRITE : MEM_READ;
      r_be   = mem_be_t'($urandom_range(15, 1));
      if (!known[r_addr]) begin  // First touch fills the whole word
        r_op = MEM_WRITE;
        r_be = '1;
      end
      issue(p, r_op, r_addr, r_be, mem_data_t'($urandom()));
    end
  endtask

  task automatic finish_test(input string name);
    if (fail_cnt == fail_at_start) begin
      tests_passed++;
      $display("Test %-18s passed", name);
    end else begin
      tests_failed++;
      $display("Test %-18s FAILED with %0d errors", name, fail_cnt - fail_at_start);
    end
    fail_at_start = fail_cnt;
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    clk       = 1'b0;
    arst_n_i  = 1'b0;
    req       = 2'b00;
    exp_state = PRIO_PORT0;
    for (int p = 0; p < 2; p++) begin
      op[p]    = MEM_READ;
      addr[p]  = '0;
      be[p]    = '0;
      wdata[p] = '0;
    end
    for (int i = 0; i < `MEM_DEPTH; i++) known[i] = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n_i = 1'b1;

    repeat (IDLE_CYCLES) begin  // Monitor expects silence
      @(posedge clk);
      #2;
    end
    finish_test("idle_after_reset");

    // Writes then reads, both ports every round
    for (int r = 0; r < N_CONTENTION; r++) begin
      fork
        issue(PORT0, (r < N_CONTENTION / 2) ? MEM_WRITE : MEM_READ,
              mem_addr_t'(2 * (r % (N_CONTENTION / 2))), '1, mem_data_t'($urandom()));
        issue(PORT1, (r < N_CONTENTION / 2) ? MEM_WRITE : MEM_READ,
              mem_addr_t'(2 * (r % (N_CONTENTION / 2)) + 1), '1, mem_data_t'($urandom()));
      join
    end
    finish_test("contention");

    issue(PORT0, MEM_WRITE, mem_addr_t'(10'h100), '1, 32'hC0DE_5A17);
    issue(PORT1, MEM_READ, mem_addr_t'(10'h100), '0, '0);
    issue(PORT0, MEM_READ, mem_addr_t'(10'h100), '0, '0);
    finish_test("write_readback");

    // Reader accepted the cycle after the writer
    for (int i = 0; i < N_CROSS; i++) begin
      fork
        issue(i[0] ? PORT1 : PORT0, MEM_WRITE, mem_addr_t'(10'h200 + i), '1,
              mem_data_t'($urandom()));
        begin
          @(posedge clk);
          #2;
          issue(i[0] ? PORT0 : PORT1, MEM_READ, mem_addr_t'(10'h200 + i), '0, '0);
        end
      join
    end
    finish_test("cross_port");

    fork
      random_port(PORT0, N_RANDOM);
      random_port(PORT1, N_RANDOM);
    join
    repeat (2) begin  // Drain the last response
      @(posedge clk);
      #2;
    end
    if (resp_q[0].size() != 0 || resp_q[1].size() != 0) begin
      fail_cnt++;
      $display("Responses were still expected when the traffic ended");
    end
    finish_test("random_traffic");

    $display("Tests: %0d passed, %0d failed. Checks: %0d passed, %0d failed",
             tests_passed, tests_failed, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/arb_pkg.sv
hdl/sp_ram.sv
hdl/ram_mux.sv
hdl/mem_subsys.sv
tests/mem_subsys_properties.sv
tests/mem_subsys_tb.sv

//--- Makefile
# Verilator build and run for the data memory subsystem

TOP := mem_subsys_tb
LOG := sim.log

SOURCES := files.f hdl/mem_consts.svh $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

# Pass only when the exact pass line shows up in the log
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "All checks passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
